/* src/cachePkg.sv */
// Cache geometry constants, state encodings, address union and line type
package cachePkg;

    // Word and line geometry
    localparam int WordWidth    = 16;
    localparam int WordsPerLine = 8;
    localparam int OffsetWidth  = 3;
    localparam int IndexWidth   = 11;
    localparam int TagWidth     = 2;
    localparam int AddrWidth    = 16;
    localparam int NumLines     = 2048;

    // Front end states
    localparam logic [1:0] FeIdle     = 2'd0;
    localparam logic [1:0] FeLookup   = 2'd1;
    localparam logic [1:0] FeWait     = 2'd2;
    localparam logic [1:0] FeRelookup = 2'd3;

    // Fill engine states
    localparam logic [2:0] FillIdle      = 3'd0;
    localparam logic [2:0] FillWriteBack = 3'd1;
    localparam logic [2:0] FillRead      = 3'd2;
    localparam logic [2:0] FillInstall   = 3'd3;
    localparam logic [2:0] FillDone      = 3'd4;

    // Refill walk is eight reads plus one cycle for the last data word
    localparam logic [3:0] ReadLastCount = 4'd8;

    // Word address seen two ways
    // Cache side splits it into fields, memory side uses it flat
    typedef union packed {
        struct packed {
            logic [TagWidth-1:0]    tag;
            logic [IndexWidth-1:0]  index;
            logic [OffsetWidth-1:0] offset;
        } field;
        logic [AddrWidth-1:0] flat;
    } cacheAddr_u;

    // One cache line, word 0 in the low bits
    typedef logic [WordsPerLine-1:0][WordWidth-1:0] cacheLine_t;

endpackage

/* src/mainMemory.sv */
// Synchronous 64K word main memory with registered read data and fixed preload
`timescale 1ns/1ps

module mainMemory (
    input  logic                 clk,
    input  cachePkg::cacheAddr_u memAddr,
    input  logic                 memWrite,
    input  logic [15:0]          memWriteData,
    output logic [15:0]          memReadData
);
    import cachePkg::*;

    logic [WordWidth-1:0] mem [2**AddrWidth];

    // Preload pattern, word equals its address XOR 5A5A
    initial begin
        for (int i = 0; i < 2**AddrWidth; i++) begin
            mem[i] = 16'(i) ^ 16'h5A5A;
        end
    end

    // Flat view of the address indexes the array
    always_ff @(posedge clk) begin
        if (memWrite) begin
            mem[memAddr.flat] <= memWriteData;
        end
        // Old data on a same-cycle write
        memReadData <= mem[memAddr.flat];
    end

endmodule

/* src/cacheLineStore.sv */
// Line data, tag, valid and dirty arrays with lookup, word write and line install
`timescale 1ns/1ps

module cacheLineStore (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 lookup,
    input  cachePkg::cacheAddr_u lookupAddr,
    input  logic                 wordWrite,
    input  logic [15:0]          wordData,
    output logic                 hit,
    output logic [15:0]          readWord,
    output logic                 victimDirty,
    output logic [1:0]           victimTag,
    output cachePkg::cacheLine_t victimLine,
    input  logic                 lineInstall,
    input  cachePkg::cacheLine_t installLine,
    input  logic [1:0]           installTag
);
    import cachePkg::*;

    // Storage arrays
    cacheLine_t              dataArray [NumLines];
    logic [TagWidth-1:0]     tagArray  [NumLines];
    logic [NumLines-1:0]     validBits;
    logic [NumLines-1:0]     dirtyBits;

    // Position of the current access, held until the next lookup
    logic [IndexWidth-1:0]   curIndex;
    logic [OffsetWidth-1:0]  curOffset;

    // Tag match against the addressed line
    logic                    tagMatch;

    assign tagMatch = (tagArray[lookupAddr.field.index] == lookupAddr.field.tag);

    // Hit is control state and starts cleared
    always_ff @(posedge clk) begin
        if (rst) begin
            hit <= 1'b0;
        end else if (lookup) begin
            hit <= tagMatch && validBits[lookupAddr.field.index];
        end
    end

    // Lookup answers and access position
    always_ff @(posedge clk) begin
        if (lookup) begin
            curIndex    <= lookupAddr.field.index;
            curOffset   <= lookupAddr.field.offset;
            readWord    <= dataArray[lookupAddr.field.index][lookupAddr.field.offset];
            victimTag   <= tagArray[lookupAddr.field.index];
            victimLine  <= dataArray[lookupAddr.field.index];
        end
    end

    // Victim dirty state read alongside the other answers
    always_ff @(posedge clk) begin
        if (rst) begin
            victimDirty <= 1'b0;
        end else if (lookup) begin
            victimDirty <= dirtyBits[lookupAddr.field.index];
        end
    end

    // Valid and dirty per line
    always_ff @(posedge clk) begin
        if (rst) begin
            validBits <= '0;
            dirtyBits <= '0;
        end else if (lineInstall) begin
            // Fresh copy from memory is clean
            validBits[curIndex] <= 1'b1;
            dirtyBits[curIndex] <= 1'b0;
        end else if (wordWrite) begin
            dirtyBits[curIndex] <= 1'b1;
        end
    end

    // Data and tag updates
    always_ff @(posedge clk) begin
        if (lineInstall) begin
            dataArray[curIndex] <= installLine;
            tagArray[curIndex]  <= installTag;
        end else if (wordWrite) begin
            // Single word of the line latched at lookup
            dataArray[curIndex][curOffset] <= wordData;
        end
    end

endmodule

/* src/lineFillEngine.sv */
// Write-back and refill sequencer moving one cache line to and from main memory
`timescale 1ns/1ps

module lineFillEngine (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 fillStart,
    input  cachePkg::cacheAddr_u lookupAddr,
    input  logic                 victimDirty,
    input  logic [1:0]           victimTag,
    input  cachePkg::cacheLine_t victimLine,
    output logic                 lineInstall,
    output cachePkg::cacheLine_t installLine,
    output logic [1:0]           installTag,
    output logic                 fillDone,
    output cachePkg::cacheAddr_u memAddr,
    output logic                 memWrite,
    output logic [15:0]          memWriteData,
    input  logic [15:0]          memReadData
);
    import cachePkg::*;

    logic [2:0]             state;
    // Word counter, one extra step on the read side
    logic [3:0]             count;
    // Slot of the word returned by the previous read
    logic [OffsetWidth-1:0] prevSlot;
    cacheLine_t             fillLine;

    assign prevSlot = count[OffsetWidth-1:0] - 3'd1;

    assign memWrite     = (state == FillWriteBack);
    assign memWriteData = victimLine[count[OffsetWidth-1:0]];
    assign lineInstall  = (state == FillInstall);
    assign fillDone     = (state == FillDone);
    assign installLine  = fillLine;
    assign installTag   = lookupAddr.field.tag;

    // Address fields, victim tag while writing back, request tag otherwise
    always_comb begin
        memAddr.field.index  = lookupAddr.field.index;
        memAddr.field.offset = count[OffsetWidth-1:0];
        if (state == FillWriteBack) begin
            memAddr.field.tag = victimTag;
        end else begin
            memAddr.field.tag = lookupAddr.field.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FillIdle;
            count <= '0;
        end else begin
            case (state)
                FillIdle: begin
                    count <= '0;
                    if (fillStart) begin
                        // Clean victim skips straight to the refill
                        state <= victimDirty ? FillWriteBack : FillRead;
                    end
                end
                FillWriteBack: begin
                    if (count == 4'd7) begin
                        count <= '0;
                        state <= FillRead;
                    end else begin
                        count <= count + 4'd1;
                    end
                end
                FillRead: begin
                    if (count == ReadLastCount) begin
                        count <= '0;
                        state <= FillInstall;
                    end else begin
                        count <= count + 4'd1;
                    end
                end
                FillInstall: begin
                    state <= FillDone;
                end
                default: begin
                    state <= FillIdle;
                end
            endcase
        end
    end

    // Memory data trails its address by one cycle
    // Last word arrives at count 8, where prevSlot wraps to 7
    always_ff @(posedge clk) begin
        if ((state == FillRead) && (count != 4'd0)) begin
            fillLine[prevSlot] <= memReadData;
        end
    end

endmodule

/* src/apbCacheFrontEnd.sv */
// APB slave FSM issuing cache lookups, word writes and fill requests
`timescale 1ns/1ps

module apbCacheFrontEnd (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     PSEL,
    input  logic                     PENABLE,
    input  logic                     PWRITE,
    input  cachePkg::cacheAddr_u     PADDR,
    input  logic [15:0]              PWDATA,
    output logic [15:0]              PRDATA,
    output logic                     PREADY,
    output logic                     hitFlag,
    output logic                     lookup,
    output cachePkg::cacheAddr_u     lookupAddr,
    output logic                     wordWrite,
    output logic [15:0]              wordData,
    input  logic                     hit,
    input  logic [15:0]              readWord,
    output logic                     fillStart,
    input  logic                     fillDone
);
    import cachePkg::*;

    logic [1:0] state;
    logic [1:0] stateNext;

    // Host holds PADDR for the whole access, so it feeds the store directly
    assign lookupAddr = PADDR;
    assign wordData   = PWDATA;

    // Lookup on access entry, and again once the line is in place
    assign lookup = ((state == FeIdle) && PSEL && PENABLE) ||
                    ((state == FeWait) && fillDone);

    // Second lookup after a fill always hits
    assign PREADY = ((state == FeLookup) && hit) || (state == FeRelookup);

    // Write lands at the edge closing the ready cycle
    assign wordWrite = PREADY && PWRITE;
    assign PRDATA    = readWord;

    // Miss on the first lookup hands over to the fill engine
    assign fillStart = (state == FeLookup) && !hit;

    // A ready cycle in the lookup state is a first lookup hit
    // Relookup is only reached after a first lookup miss
    assign hitFlag = PREADY && (state == FeLookup);

    always_comb begin
        stateNext = state;
        case (state)
            FeIdle: begin
                if (PSEL && PENABLE) begin
                    stateNext = FeLookup;
                end
            end
            FeLookup: begin
                // Hit finishes here, miss waits for the line
                stateNext = hit ? FeIdle : FeWait;
            end
            FeWait: begin
                if (fillDone) begin
                    stateNext = FeRelookup;
                end
            end
            default: begin
                stateNext = FeIdle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FeIdle;
        end else begin
            state <= stateNext;
        end
    end

endmodule

/* src/cacheTop.sv */
// Cache top level joining APB front end, line store, fill engine and main memory
`timescale 1ns/1ps

module cacheTop (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 PSEL,
    input  logic                 PENABLE,
    input  logic                 PWRITE,
    input  cachePkg::cacheAddr_u PADDR,
    input  logic [15:0]          PWDATA,
    output logic [15:0]          PRDATA,
    output logic                 PREADY,
    output logic                 hitFlag
);
    import cachePkg::*;

    // Front end to line store
    logic                 lookup;
    cacheAddr_u           lookupAddr;
    logic                 wordWrite;
    logic [WordWidth-1:0] wordData;
    logic                 hit;
    logic [WordWidth-1:0] readWord;

    // Victim and install paths
    logic                 victimDirty;
    logic [TagWidth-1:0]  victimTag;
    cacheLine_t           victimLine;
    logic                 lineInstall;
    cacheLine_t           installLine;
    logic [TagWidth-1:0]  installTag;

    // Fill handshake
    logic                 fillStart;
    logic                 fillDone;

    // Memory port
    cacheAddr_u           memAddr;
    logic                 memWrite;
    logic [WordWidth-1:0] memWriteData;
    logic [WordWidth-1:0] memReadData;

    apbCacheFrontEnd frontEnd (
        .clk(clk), .rst(rst), .PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE),
        .PADDR(PADDR), .PWDATA(PWDATA), .PRDATA(PRDATA), .PREADY(PREADY),
        .hitFlag(hitFlag), .lookup(lookup), .lookupAddr(lookupAddr),
        .wordWrite(wordWrite), .wordData(wordData), .hit(hit), .readWord(readWord),
        .fillStart(fillStart), .fillDone(fillDone)
    );

    cacheLineStore lineStore (
        .clk(clk), .rst(rst), .lookup(lookup), .lookupAddr(lookupAddr),
        .wordWrite(wordWrite), .wordData(wordData), .hit(hit), .readWord(readWord),
        .victimDirty(victimDirty), .victimTag(victimTag), .victimLine(victimLine),
        .lineInstall(lineInstall), .installLine(installLine), .installTag(installTag)
    );

    lineFillEngine fillEngine (
        .clk(clk), .rst(rst), .fillStart(fillStart), .lookupAddr(lookupAddr),
        .victimDirty(victimDirty), .victimTag(victimTag), .victimLine(victimLine),
        .lineInstall(lineInstall), .installLine(installLine), .installTag(installTag),
        .fillDone(fillDone), .memAddr(memAddr), .memWrite(memWrite),
        .memWriteData(memWriteData), .memReadData(memReadData)
    );

    mainMemory memory (
        .clk(clk), .memAddr(memAddr), .memWrite(memWrite),
        .memWriteData(memWriteData), .memReadData(memReadData)
    );

endmodule

/* testbench/cacheTb_chk.sv */
// Bound assertions on the APB handshake and the fill request protocol
`timescale 1ns/1ps

module cacheTb_chk (
    input logic                 clk,
    input logic                 rst,
    input logic                 PSEL,
    input logic                 PENABLE,
    input logic                 PREADY,
    input cachePkg::cacheAddr_u PADDR,
    input logic                 fillStart,
    input logic                 fillDone,
    input logic                 lineInstall
);
    // Fill request outstanding
    logic fillBusy;

    always_ff @(posedge clk) begin
        if (rst) begin
            fillBusy <= 1'b0;
        end else if (fillStart) begin
            fillBusy <= 1'b1;
        end else if (fillDone) begin
            fillBusy <= 1'b0;
        end
    end

    // Ready only inside an access phase
    readyInAccess: assert property (@(posedge clk) disable iff (rst)
        PREADY |-> (PSEL && PENABLE))
        else $error("PREADY high outside an access phase");

    // Address held while the access waits
    addrStable: assert property (@(posedge clk) disable iff (rst)
        (PSEL && PENABLE && !PREADY) |=> $stable(PADDR))
        else $error("PADDR changed during an access");

    // No second request until the first one is done
    noRefill: assert property (@(posedge clk) disable iff (rst)
        fillStart |-> !fillBusy)
        else $error("fillStart repeated before fillDone");

    // Install comes right before done
    installFirst: assert property (@(posedge clk) disable iff (rst)
        fillDone |-> $past(lineInstall))
        else $error("fillDone without a preceding lineInstall");

endmodule

bind cacheTop cacheTb_chk chk (
    .clk(clk), .rst(rst), .PSEL(PSEL), .PENABLE(PENABLE), .PREADY(PREADY),
    .PADDR(PADDR), .fillStart(fillStart), .fillDone(fillDone), .lineInstall(lineInstall)
);

/* testbench/cacheTb.sv */
// Cache testbench with clock, reset, reference model, APB tasks, compare tasks and tests
`timescale 1ns/1ps

module cacheTb;
    import cachePkg::*;

    logic                 clk;
    logic                 rst;
    logic                 PSEL;
    logic                 PENABLE;
    logic                 PWRITE;
    cacheAddr_u           PADDR;
    logic [WordWidth-1:0] PWDATA;
    logic [WordWidth-1:0] PRDATA;
    logic                 PREADY;
    logic                 hitFlag;

    // Reference model, flat word space plus tag and valid shadows per line
    logic [WordWidth-1:0] refMem [2**AddrWidth];
    logic [TagWidth-1:0]  tagShadow [NumLines];
    logic [NumLines-1:0]  validShadow;

    int dataErrors;
    int hitErrors;
    int timeoutErrors;

    cacheTop UUT (
        .clk(clk), .rst(rst), .PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE),
        .PADDR(PADDR), .PWDATA(PWDATA), .PRDATA(PRDATA), .PREADY(PREADY),
        .hitFlag(hitFlag)
    );

    always #10 clk = ~clk;

    function automatic cacheAddr_u makeAddr(input logic [TagWidth-1:0] tag,
                                            input logic [IndexWidth-1:0] index,
                                            input logic [OffsetWidth-1:0] offset);
        cacheAddr_u a;
        a.field.tag    = tag;
        a.field.index  = index;
        a.field.offset = offset;
        return a;
    endfunction

    // Direct mapped, so a hit needs a valid line with the same tag
    function automatic logic predictHit(input cacheAddr_u addr);
        return validShadow[addr.field.index] &&
               (tagShadow[addr.field.index] == addr.field.tag);
    endfunction

    // Every access leaves its line resident, write misses allocate too
    function automatic void allocateLine(input cacheAddr_u addr);
        validShadow[addr.field.index] = 1'b1;
        tagShadow[addr.field.index]   = addr.field.tag;
    endfunction

    task automatic checkWord(input string sigName, input cacheAddr_u addr,
                             input logic [WordWidth-1:0] actual,
                             input logic [WordWidth-1:0] expected);
        if (actual !== expected) begin
            dataErrors++;
            $display("** Error: %s at address %h: got %h, expected %h",
                     sigName, addr.flat, actual, expected);
        end
    endtask

    task automatic checkHit(input string sigName, input cacheAddr_u addr,
                            input logic actual, input logic expected);
        if (actual !== expected) begin
            hitErrors++;
            $display("** Error: %s at address %h: got %h, expected %h",
                     sigName, addr.flat, actual, expected);
        end
    endtask

    // Setup phase, then access phase one cycle later
    task automatic startTransfer(input logic write, input cacheAddr_u addr,
                                 input logic [WordWidth-1:0] data);
        @(negedge clk);
        PSEL    = 1'b1;
        PENABLE = 1'b0;
        PWRITE  = write;
        PADDR   = addr;
        PWDATA  = data;
        @(negedge clk);
        PENABLE = 1'b1;
    endtask

    // PREADY settles after the rising edge, so look at it on the falling one
    task automatic waitReady(output logic [WordWidth-1:0] data, output logic hf,
                             output logic done);
        int cycles;
        cycles = 0;
        done   = 1'b0;
        data   = '0;
        hf     = 1'b0;
        while (!done && cycles < 100) begin
            @(negedge clk);
            if (PREADY) begin
                data = PRDATA;
                hf   = hitFlag;
                done = 1'b1;
            end
            cycles++;
        end
        // Transfer closes on the edge after the ready cycle
        @(negedge clk);
        PSEL    = 1'b0;
        PENABLE = 1'b0;
    endtask

    task automatic apbRead(input cacheAddr_u addr, output logic [WordWidth-1:0] data,
                           output logic hf, output logic done);
        startTransfer(1'b0, addr, '0);
        waitReady(data, hf, done);
        if (!done) begin
            timeoutErrors++;
            $display("Read of address %h got no PREADY within 100 cycles", addr.flat);
        end
    endtask

    task automatic apbWrite(input cacheAddr_u addr, input logic [WordWidth-1:0] data,
                            output logic hf, output logic done);
        logic [WordWidth-1:0] unused;
        startTransfer(1'b1, addr, data);
        waitReady(unused, hf, done);
        if (!done) begin
            timeoutErrors++;
            $display("Write to address %h got no PREADY within 100 cycles", addr.flat);
        end
    endtask

    task automatic readCheck(input cacheAddr_u addr, input logic expHit);
        logic [WordWidth-1:0] got;
        logic                 gotHit;
        logic                 done;
        apbRead(addr, got, gotHit, done);
        if (done) begin
            checkHit("hitFlag", addr, gotHit, expHit);
            checkWord("PRDATA", addr, got, refMem[addr.flat]);
        end
        allocateLine(addr);
    endtask

    task automatic writeCheck(input cacheAddr_u addr, input logic [WordWidth-1:0] data,
                              input logic expHit);
        logic gotHit;
        logic done;
        apbWrite(addr, data, gotHit, done);
        if (done) begin
            checkHit("hitFlag", addr, gotHit, expHit);
        end
        refMem[addr.flat] = data;
        allocateLine(addr);
    endtask

    // Cold read misses, then the rest of that line hits
    task automatic testReads();
        readCheck(makeAddr(2'd0, 11'd5, 3'd3), 1'b0);
        for (int off = 0; off < WordsPerLine; off++) begin
            readCheck(makeAddr(2'd0, 11'd5, 3'(off)), 1'b1);
        end
    endtask

    task automatic testWriteHit();
        writeCheck(makeAddr(2'd0, 11'd5, 3'd2), 16'hBEEF, 1'b1);
        readCheck(makeAddr(2'd0, 11'd5, 3'd2), 1'b1);
    endtask

    // Write miss allocates, neighbours keep memory values
    task automatic testWriteMiss();
        writeCheck(makeAddr(2'd1, 11'd9, 3'd4), 16'h1234, 1'b0);
        readCheck(makeAddr(2'd1, 11'd9, 3'd0), 1'b1);
        readCheck(makeAddr(2'd1, 11'd9, 3'd4), 1'b1);
    endtask

    // Dirty line pushed out by a conflicting tag, then fetched back
    task automatic testEviction();
        writeCheck(makeAddr(2'd2, 11'd20, 3'd6), 16'hC0DE, 1'b0);
        readCheck(makeAddr(2'd3, 11'd20, 3'd1), 1'b0);
        readCheck(makeAddr(2'd2, 11'd20, 3'd6), 1'b0);
    endtask

    task automatic testRandom();
        logic [IndexWidth-1:0] indexSet [4];
        logic [31:0]           r;
        cacheAddr_u            addr;
        indexSet = '{11'd100, 11'd101, 11'd1500, 11'd2047};
        for (int i = 0; i < 200; i++) begin
            r    = $urandom;
            addr = makeAddr(r[1:0], indexSet[r[3:2]], r[6:4]);
            if (r[7]) begin
                writeCheck(addr, r[31:16], predictHit(addr));
            end else begin
                readCheck(addr, predictHit(addr));
            end
        end
    endtask

    initial begin
        int unsigned seedValue;
        clk           = 1'b0;
        rst           = 1'b1;
        PSEL          = 1'b0;
        PENABLE       = 1'b0;
        PWRITE        = 1'b0;
        PADDR         = '0;
        PWDATA        = '0;
        dataErrors    = 0;
        hitErrors     = 0;
        timeoutErrors = 0;
        // Same preload rule as the memory behind the cache
        for (int i = 0; i < 2**AddrWidth; i++) begin
            refMem[i] = 16'(i) ^ 16'h5A5A;
        end
        for (int i = 0; i < NumLines; i++) begin
            tagShadow[i] = '0;
        end
        validShadow = '0;
        seedValue   = $urandom(32'ha5b04627);
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        testReads();
        testWriteHit();
        testWriteMiss();
        testEviction();
        testRandom();
        $display("Errors: data %0d, hit %0d, timeout %0d", dataErrors, hitErrors,
                 timeoutErrors);
        if ((dataErrors + hitErrors + timeoutErrors) == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
src/cachePkg.sv
src/mainMemory.sv
src/cacheLineStore.sv
src/lineFillEngine.sv
src/apbCacheFrontEnd.sv
src/cacheTop.sv
testbench/cacheTb_chk.sv
testbench/cacheTb.sv

/* runSim.sh */
#!/bin/sh
# Build the cache testbench with Verilator, run it and check the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f verilog.f --top-module cacheTb -o cacheSim \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/cacheSim > sim.log 2>&1
cat sim.log
grep -q "sim passed" sim.log && echo "Simulation OK" \
    || { echo "Simulation reported failure"; exit 1; }
